/* build.f */
+incdir+.
eth_tx_pkg.sv
eth_tx_regs.sv
eth_tx_chan.sv
eth_tx_arb.sv
eth_tx_framer.sv
eth_tx_top.sv
eth_tx_tb.sv

/* eth_tx_arb.sv */
`include "eth_tx_macros.svh"

module eth_tx_arb (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         start_rdy,
  input  logic                                         pop,
  input  logic [`ETH_TX_CHANNELS-1:0]                  req,
  input  eth_tx_pkg::tx_desc_t [`ETH_TX_CHANNELS-1:0]  desc_in,
  input  eth_tx_pkg::tx_byte_t [`ETH_TX_CHANNELS-1:0]  head_in,
  output logic [`ETH_TX_CHANNELS-1:0]                  grant,
  output eth_tx_pkg::tx_desc_t                         desc,
  output eth_tx_pkg::tx_byte_t                         head,
  output logic                                         start,
  output logic [`ETH_TX_CHANNELS-1:0]                  chan_pop
);

  localparam int N  = `ETH_TX_CHANNELS;
  localparam int IW = $clog2(N);

  logic [IW-1:0] sel;    // Last grant, held for the whole frame
  logic [IW-1:0] pick;
  logic          found;

  // Search starts one past the last grant
  always_comb begin
    pick  = sel;
    found = 1'b0;
    for (int i = 1; i <= N; i++) begin
      if (!found && req[(int'(sel) + i) % N]) begin
        pick  = IW'((int'(sel) + i) % N);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      start <= 1'b0;
      sel   <= IW'(N - 1);  // First search begins at channel 0
    end else begin
      grant <= '0;
      start <= 1'b0;
      // Framer still reads idle in the start cycle
      if (start_rdy && !start && found) begin
        grant[pick] <= 1'b1;
        start       <= 1'b1;
        sel         <= pick;
      end
    end
  end

  assign desc = desc_in[sel];
  assign head = head_in[sel];

  always_comb begin
    chan_pop      = '0;
    chan_pop[sel] = pop;
  end

endmodule

/* eth_tx_chan.sv */
`include "eth_tx_macros.svh"

module eth_tx_chan (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     desc_lo_we,
  input  logic                     desc_hi_we,
  input  logic                     push,
  input  logic                     arm,
  input  logic                     grant,
  input  logic                     pop,
  input  logic [31:0]              wdata,
  output logic                     req,
  output logic                     busy,
  output logic [`ETH_TX_LEN_W-1:0] len,
  output eth_tx_pkg::tx_desc_t     desc,
  output eth_tx_pkg::tx_byte_t     head
);

  localparam int DEPTH = `ETH_TX_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  logic [7:0]               mem [DEPTH];
  logic [`ETH_TX_LEN_W-1:0] wr_ptr;
  logic [`ETH_TX_LEN_W-1:0] rd_ptr;
  eth_tx_pkg::mac_addr_t    dst;
  eth_tx_pkg::ethertype_t   etype;
  logic                     granted;
  logic                     load_ok;
  logic                     arm_ok;
  logic                     pop_ok;

  assign load_ok = push && !busy && (wr_ptr != `ETH_TX_LEN_W'(DEPTH));
  assign arm_ok  = arm && !busy && (wr_ptr != '0);  // Empty channel stays idle
  assign pop_ok  = pop && granted;

  // Request straight from the arm strobe saves a cycle to the arbiter
  assign req = busy || arm_ok;
  assign len = wr_ptr;  // Pointers restart at zero each frame

  assign desc      = '{dst: dst, ethertype: etype, len: wr_ptr};
  assign head.dat  = mem[rd_ptr[AW-1:0]];
  assign head.last = (rd_ptr + 1'b1 == wr_ptr);

  // Descriptor and payload frozen while the frame is out
  always_ff @(posedge clk) begin
    if (desc_lo_we && !busy) dst[31:0] <= wdata;
    if (desc_hi_we && !busy) begin
      dst[47:32] <= wdata[15:0];
      etype      <= wdata[31:16];
    end
    if (load_ok) mem[wr_ptr[AW-1:0]] <= wdata[7:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      busy    <= 1'b0;
      granted <= 1'b0;
    end else begin
      if (load_ok) wr_ptr <= wr_ptr + 1'b1;
      if (arm_ok) busy <= 1'b1;
      if (grant) granted <= 1'b1;
      if (pop_ok) begin
        if (head.last) begin  // Frame drained, ready for reload
          wr_ptr  <= '0;
          rd_ptr  <= '0;
          busy    <= 1'b0;
          granted <= 1'b0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

endmodule

/* eth_tx_framer.sv */
`include "eth_tx_macros.svh"

module eth_tx_framer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  eth_tx_pkg::tx_desc_t desc,
  input  eth_tx_pkg::tx_byte_t head,
  output logic                 start_rdy,
  output logic                 pop,
  output logic                 tx_val,
  output logic                 tx_sof,
  output logic                 tx_eof,
  output logic [7:0]           tx_dat
);

  localparam int HW = 8 * `ETH_TX_HDR_LEN;

  typedef enum logic [2:0] {
    st_idle, st_header, st_payload, st_pad, st_fcs, st_gap
  } state_t;

  state_t          state, state_d;
  logic [6:0]      cnt, cnt_d;
  logic [31:0]     crc, crc_d;
  logic [31:0]     fcs;
  logic [HW-1:0]   hdr;
  logic [7:0]      byte_d;
  logic            val_d;
  logic            sof_d;
  logic            eof_d;

  // Reflected CRC-32, one byte LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] b);
    logic [31:0] c;
    c = crc_in ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
    end
    return c;
  endfunction

  assign hdr       = {desc.dst, 48'(`ETH_TX_SRC_MAC), desc.ethertype};
  assign fcs       = ~crc;
  assign start_rdy = (state == st_idle);

  ////////////////////////////////////////////////////////////////////////////
  // Next byte and state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state;
    cnt_d   = cnt + 7'd1;
    byte_d  = 8'h00;
    val_d   = 1'b0;
    sof_d   = 1'b0;
    eof_d   = 1'b0;
    pop     = 1'b0;
    case (state)
      st_idle: begin
        cnt_d = '0;
        if (start) begin
          val_d   = 1'b1;
          sof_d   = 1'b1;
          byte_d  = hdr[HW-1 -: 8];  // Destination MSB first
          cnt_d   = 7'd1;
          state_d = st_header;
        end
      end
      st_header: begin
        val_d  = 1'b1;
        byte_d = hdr[8 * (`ETH_TX_HDR_LEN - 1 - int'(cnt)) +: 8];
        if (cnt == 7'(`ETH_TX_HDR_LEN - 1)) begin
          cnt_d   = '0;
          state_d = (desc.len == '0) ? st_pad : st_payload;
        end
      end
      st_payload: begin
        val_d  = 1'b1;
        pop    = 1'b1;
        byte_d = head.dat;
        if (head.last) begin
          if (desc.len < `ETH_TX_MIN_PAYLOAD) begin
            state_d = st_pad;  // cnt keeps counting payload bytes
          end else begin
            cnt_d   = '0;
            state_d = st_fcs;
          end
        end
      end
      st_pad: begin
        val_d = 1'b1;
        if (cnt == 7'(`ETH_TX_MIN_PAYLOAD - 1)) begin
          cnt_d   = '0;
          state_d = st_fcs;
        end
      end
      st_fcs: begin
        val_d  = 1'b1;
        byte_d = fcs[8 * cnt[1:0] +: 8];  // Low byte first
        if (cnt == 7'(`ETH_TX_FCS_LEN - 1)) begin
          eof_d   = 1'b1;
          cnt_d   = '0;
          state_d = st_gap;
        end
      end
      default: begin  // Inter-frame gap
        if (cnt == 7'(`ETH_TX_IFG - 1)) state_d = st_idle;
      end
    endcase
  end

  // CRC covers everything ahead of the FCS
  always_comb begin
    crc_d = crc;
    if (val_d && state != st_fcs) begin
      crc_d = crc_byte((state == st_idle) ? 32'hffffffff : crc, byte_d);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      cnt    <= '0;
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
    end else begin
      state  <= state_d;
      cnt    <= cnt_d;
      tx_val <= val_d;
      tx_sof <= sof_d;
      tx_eof <= eof_d;
    end
  end

  always_ff @(posedge clk) begin
    tx_dat <= byte_d;
    crc    <= crc_d;
  end

endmodule

/* eth_tx_macros.svh */
`ifndef ETH_TX_MACROS_SVH
`define ETH_TX_MACROS_SVH

// Channel count and per-channel payload storage
`define ETH_TX_CHANNELS    4
`define ETH_TX_FIFO_DEPTH  64
`define ETH_TX_LEN_W       7    // Holds 0..FIFO_DEPTH

// Locally administered station address
`define ETH_TX_SRC_MAC     48'h02_1a_3c_5e_70_91

// Frame layout in bytes
`define ETH_TX_HDR_LEN     14   // dst + src + EtherType
`define ETH_TX_MIN_PAYLOAD 46
`define ETH_TX_FCS_LEN     4
`define ETH_TX_IFG         12

`endif

/* eth_tx_pkg.sv */
`include "eth_tx_macros.svh"

package eth_tx_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;

  ////////////////////////////////////////////////////////////////////////////
  // Channel side
  ////////////////////////////////////////////////////////////////////////////

  // Frame metadata as presented by a channel
  typedef struct packed {
    mac_addr_t                dst;
    ethertype_t               ethertype;
    logic [`ETH_TX_LEN_W-1:0] len;       // Payload bytes held
  } tx_desc_t;

  // Byte at the FIFO head
  typedef struct packed {
    logic [7:0] dat;
    logic       last;  // Only byte left
  } tx_byte_t;

  ////////////////////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////////////////////

  // Low two bits of the Wishbone word address
  typedef enum logic [1:0] {
    dst_lo = 2'd0,  // dst[31:0]
    dst_hi = 2'd1,  // dst[47:32], EtherType in upper half
    data   = 2'd2,  // Payload byte push
    ctrl   = 2'd3   // Arm on write, status on read
  } wb_reg_t;

endpackage

/* eth_tx_regs.sv */
`include "eth_tx_macros.svh"

module eth_tx_regs (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             wb_cyc,
  input  logic                                             wb_stb,
  input  logic                                             wb_we,
  input  logic [3:0]                                       wb_adr,
  input  logic [31:0]                                      wb_dat_w,
  output logic [31:0]                                      wb_dat_r,
  output logic                                             wb_ack,
  input  logic [`ETH_TX_CHANNELS-1:0]                      chan_busy,
  input  logic [`ETH_TX_CHANNELS-1:0][`ETH_TX_LEN_W-1:0]   chan_len,
  output logic [`ETH_TX_CHANNELS-1:0]                      desc_lo_we,
  output logic [`ETH_TX_CHANNELS-1:0]                      desc_hi_we,
  output logic [`ETH_TX_CHANNELS-1:0]                      push,
  output logic [`ETH_TX_CHANNELS-1:0]                      arm,
  output logic [31:0]                                      wdata
);

  localparam int CW = $clog2(`ETH_TX_CHANNELS);

  logic                 access;
  logic [CW-1:0]        ch;
  eth_tx_pkg::wb_reg_t  reg_sel;
  logic [31:0]          status;

  // New access only while no ack is pending
  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign ch      = wb_adr[2 +: CW];
  assign reg_sel = eth_tx_pkg::wb_reg_t'(wb_adr[1:0]);

  // Status word, busy in bit 0 and length in 14:8
  assign status = {17'b0, chan_len[ch], 7'b0, chan_busy[ch]};

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack     <= 1'b0;
      desc_lo_we <= '0;
      desc_hi_we <= '0;
      push       <= '0;
      arm        <= '0;
    end else begin
      wb_ack     <= access;
      desc_lo_we <= '0;  // Strobes last one cycle
      desc_hi_we <= '0;
      push       <= '0;
      arm        <= '0;
      if (access && wb_we) begin
        case (reg_sel)
          eth_tx_pkg::dst_lo: desc_lo_we[ch] <= 1'b1;
          eth_tx_pkg::dst_hi: desc_hi_we[ch] <= 1'b1;
          eth_tx_pkg::data:   push[ch]       <= 1'b1;
          eth_tx_pkg::ctrl:   arm[ch]        <= 1'b1;
        endcase
      end
    end
  end

  // Read data and write data travel with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      wdata    <= wb_dat_w;
      wb_dat_r <= (!wb_we && reg_sel == eth_tx_pkg::ctrl) ? status : 32'h0;
    end
  end

endmodule

/* eth_tx_tb.sv */
`include "eth_tx_macros.svh"

module eth_tx_tb;

  localparam int N         = `ETH_TX_CHANNELS;
  localparam int NROWS     = 7;
  localparam int ACK_WAIT  = 8;
  localparam int IDLE_WAIT = `ETH_TX_HDR_LEN + `ETH_TX_MIN_PAYLOAD + `ETH_TX_FCS_LEN
                             + `ETH_TX_IFG + 24;  // Longer than a padded frame and its gap
  localparam logic [47:0] SRC_MAC  = `ETH_TX_SRC_MAC;
  localparam logic [31:0] CRC_POLY = 32'h04c11db7;

  // One table row per frame
  typedef struct packed {
    logic [1:0]             chan;
    eth_tx_pkg::mac_addr_t  dst;
    eth_tx_pkg::ethertype_t etype;
    logic [6:0]             len;
    logic [1:0]             order;  // Arm position within a batch
    logic                   batch;
  } row_t;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [7:0]  tx_dat;
  logic        tx_val;
  logic        tx_sof;
  logic        tx_eof;

  row_t        rows [NROWS];
  logic [7:0]  payload [NROWS][`ETH_TX_FIFO_DEPTH];
  logic [7:0]  exp_bytes [$];
  logic [7:0]  rx_bytes [$];   // All frames back to back
  int          rx_start [$];
  int          rx_len [$];
  int          frames_expected = 0;
  int          sof_count = 0;
  int          gap_count = 0;
  int          cur_len = 0;
  logic        in_frame = 1'b0;

  eth_tx_top eth_tx_top_inst (
    .clk      (clk),      .rst      (rst),
    .wb_cyc   (wb_cyc),   .wb_stb   (wb_stb),   .wb_we  (wb_we),
    .wb_adr   (wb_adr),   .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r), .wb_ack   (wb_ack),
    .tx_dat   (tx_dat),   .tx_val   (tx_val),
    .tx_sof   (tx_sof),   .tx_eof   (tx_eof)
  );

  always #20 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone host
  ////////////////////////////////////////////////////////////////////////////

  // Entered and left 5 units after a rising edge
  task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    do begin
      @(posedge clk);
      #5;
      waited++;
    end while (!wb_ack && waited < ACK_WAIT);
    assert (wb_ack) else fail_run("no wb_ack within 8 cycles of a bus access");
    assert (waited == 1)
      else fail_run($sformatf("mismatch wb_ack latency: got %h expected %h", waited, 1));
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #5;
    assert (!wb_ack) else fail_run("wb_ack stayed high for more than one cycle");
  endtask

  task automatic write_reg(input logic [1:0] ch, input eth_tx_pkg::wb_reg_t sel,
                           input logic [31:0] dat);
    logic [31:0] unused_rd;
    bus_access(1'b1, {ch, sel}, dat, unused_rd);
  endtask

  task automatic read_ctrl(input logic [1:0] ch, output logic [31:0] status);
    bus_access(1'b0, {ch, eth_tx_pkg::ctrl}, 32'h0, status);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic wait_frames(input int n);
    while (rx_len.size() < n) begin
      @(posedge clk);
      #5;
    end
  endtask

  // Descriptor and random payload, stored for the reference model
  task automatic load_row(input int r);
    write_reg(rows[r].chan, eth_tx_pkg::dst_lo, rows[r].dst[31:0]);
    write_reg(rows[r].chan, eth_tx_pkg::dst_hi, {rows[r].etype, rows[r].dst[47:32]});
    for (int k = 0; k < int'(rows[r].len); k++) begin
      payload[r][k] = 8'($urandom);
      write_reg(rows[r].chan, eth_tx_pkg::data, {24'h0, payload[r][k]});
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference frame
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_expected(input int r);
    logic [31:0] crc;
    logic [31:0] fcs;
    logic        fb;
    int          plen;
    exp_bytes.delete();
    for (int k = 5; k >= 0; k--) exp_bytes.push_back(rows[r].dst[8 * k +: 8]);
    for (int k = 5; k >= 0; k--) exp_bytes.push_back(SRC_MAC[8 * k +: 8]);
    exp_bytes.push_back(rows[r].etype[15:8]);
    exp_bytes.push_back(rows[r].etype[7:0]);
    plen = (int'(rows[r].len) > `ETH_TX_MIN_PAYLOAD) ? int'(rows[r].len) : `ETH_TX_MIN_PAYLOAD;
    for (int k = 0; k < plen; k++) begin
      exp_bytes.push_back((k < int'(rows[r].len)) ? payload[r][k] : 8'h00);
    end
    // MSB-first shift register fed LSB first, result bit-reversed
    crc = 32'hffffffff;
    foreach (exp_bytes[k]) begin
      for (int b = 0; b < 8; b++) begin
        fb  = crc[31] ^ exp_bytes[k][b];
        crc = {crc[30:0], 1'b0};
        if (fb) crc = crc ^ CRC_POLY;
      end
    end
    for (int b = 0; b < 32; b++) fcs[b] = ~crc[31 - b];
    for (int k = 0; k < 4; k++) exp_bytes.push_back(fcs[8 * k +: 8]);  // Low byte first
  endtask

  task automatic compare_frame(input int r, input int f);
    int base;
    base = rx_start[f];
    build_expected(r);
    assert (rx_len[f] == exp_bytes.size())
      else fail_run($sformatf("mismatch frame length on channel %0d: got %h expected %h",
                              rows[r].chan, rx_len[f], exp_bytes.size()));
    foreach (exp_bytes[k]) begin
      assert (rx_bytes[base + k] == exp_bytes[k])
        else fail_run($sformatf("mismatch tx_dat frame %0d byte %0d: got %h expected %h",
                                f, k, rx_bytes[base + k], exp_bytes[k]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_single(input int r);
    logic [31:0] status;
    load_row(r);
    write_reg(rows[r].chan, eth_tx_pkg::ctrl, 32'h0);  // Arm
    read_ctrl(rows[r].chan, status);
    if (rows[r].len != '0) begin
      assert (status == ((32'(rows[r].len) << 8) | 32'h1))
        else fail_run($sformatf("mismatch wb_dat_r: got %h expected %h", status,
                                (32'(rows[r].len) << 8) | 32'h1));
      frames_expected++;
      wait_frames(frames_expected);
      compare_frame(r, frames_expected - 1);
      read_ctrl(rows[r].chan, status);
      assert (status == 32'h0)
        else fail_run($sformatf("mismatch wb_dat_r: got %h expected %h", status, 32'h0));
    end else begin
      assert (status == 32'h0)
        else fail_run($sformatf("mismatch wb_dat_r: got %h expected %h", status, 32'h0));
      idle_cycles(IDLE_WAIT);
      assert (sof_count == frames_expected)
        else fail_run("arming an empty channel started a frame");
    end
  endtask

  // Load all, arm in table order, expect round robin from the first armed
  task automatic run_batch(input int lo, input int hi);
    int pending_row [N];
    int seq [$];
    int last;
    int pick;
    int base;
    for (int j = lo; j < hi; j++) load_row(j);
    for (int o = 0; o < hi - lo; o++) begin
      for (int j = lo; j < hi; j++) begin
        if (int'(rows[j].order) == o) write_reg(rows[j].chan, eth_tx_pkg::ctrl, 32'h0);
      end
    end
    for (int c = 0; c < N; c++) pending_row[c] = -1;
    for (int j = lo; j < hi; j++) pending_row[rows[j].chan] = j;
    last = 0;
    for (int j = lo; j < hi; j++) begin
      if (rows[j].order == 2'd0) last = int'(rows[j].chan);
    end
    seq.push_back(pending_row[last]);
    pending_row[last] = -1;
    for (int n = 1; n < hi - lo; n++) begin
      pick = -1;
      for (int k = 1; k <= N; k++) begin
        if (pick < 0 && pending_row[(last + k) % N] >= 0) pick = (last + k) % N;
      end
      seq.push_back(pending_row[pick]);
      pending_row[pick] = -1;
      last = pick;
    end
    base = frames_expected;
    frames_expected += hi - lo;
    wait_frames(frames_expected);
    foreach (seq[i]) compare_frame(seq[i], base + i);
  endtask

  task automatic load_table();
    rows[0] = '{chan: 2'd0, dst: 48'h00_1b_21_3a_4c_5d, etype: 16'h0800, len: 7'd60,
                order: 2'd0, batch: 1'b0};
    rows[1] = '{chan: 2'd1, dst: 48'hff_ff_ff_ff_ff_ff, etype: 16'h0806, len: 7'd10,
                order: 2'd0, batch: 1'b0};
    rows[2] = '{chan: 2'd3, dst: 48'h00_0a_95_9d_68_16, etype: 16'h88b5, len: 7'd0,
                order: 2'd0, batch: 1'b0};   // Empty channel
    rows[3] = '{chan: 2'd0, dst: 48'h00_11_22_33_44_55, etype: 16'h86dd, len: 7'd46,
                order: 2'd1, batch: 1'b1};
    rows[4] = '{chan: 2'd1, dst: 48'h00_66_77_88_99_aa, etype: 16'h0800, len: 7'd64,
                order: 2'd3, batch: 1'b1};
    rows[5] = '{chan: 2'd2, dst: 48'h01_00_5e_00_00_fb, etype: 16'h0800, len: 7'd1,
                order: 2'd0, batch: 1'b1};   // Armed first
    rows[6] = '{chan: 2'd3, dst: 48'h00_bb_cc_dd_ee_f0, etype: 16'h88cc, len: 7'd33,
                order: 2'd2, batch: 1'b1};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame monitor, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst) begin
      if (in_frame) begin
        assert (tx_val) else fail_run("tx_val dropped in the middle of a frame");
        assert (!tx_sof) else fail_run("tx_sof seen in the middle of a frame");
        rx_bytes.push_back(tx_dat);
        cur_len++;
        if (tx_eof) begin
          in_frame = 1'b0;
          rx_len.push_back(cur_len);
          gap_count = 0;
        end
      end else if (tx_val) begin
        assert (tx_sof) else fail_run("tx_val rose without tx_sof");
        assert (sof_count == 0 || gap_count >= `ETH_TX_IFG)
          else fail_run($sformatf("mismatch inter-frame gap: got %h expected at least %h",
                                  gap_count, `ETH_TX_IFG));
        sof_count++;
        rx_start.push_back(rx_bytes.size());
        rx_bytes.push_back(tx_dat);
        cur_len  = 1;
        in_frame = 1'b1;
      end else begin
        assert (!tx_sof && !tx_eof) else fail_run("tx_sof or tx_eof seen while tx_val is low");
        gap_count++;
      end
    end
  end

  // Twice the bus and line time of all rows
  initial begin : watchdog
    longint limit;
    limit = 0;
    wait (rst === 1'b0);
    for (int i = 0; i < NROWS; i++) begin
      limit += 2 * (int'(rows[i].len) + 5) + `ETH_TX_HDR_LEN + `ETH_TX_FCS_LEN + `ETH_TX_IFG;
      limit += (int'(rows[i].len) > `ETH_TX_MIN_PAYLOAD) ? int'(rows[i].len)
                                                         : `ETH_TX_MIN_PAYLOAD;
    end
    limit = 2 * limit * 40;
    #(limit);
    $display("ERRORS FOUND");
    $fatal(1, "timeout: frames still outstanding after %0d time units", limit);
  end

  initial begin : main
    int r;
    int first;
    clk      = 1'b0;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    void'($urandom(3119));
    load_table();
    repeat (2) @(posedge clk);
    #5;
    rst = 1'b0;
    r = 0;
    while (r < NROWS) begin
      if (!rows[r].batch) begin
        run_single(r);
        r++;
      end else begin
        first = r;
        while (r < NROWS && rows[r].batch) r++;
        run_batch(first, r);
      end
    end
    idle_cycles(IDLE_WAIT);
    assert (sof_count == frames_expected) else fail_run("more frames came out than were armed");
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* eth_tx_top.sv */
`include "eth_tx_macros.svh"

module eth_tx_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic [7:0]  tx_dat,
  output logic        tx_val,
  output logic        tx_sof,
  output logic        tx_eof
);

  localparam int N = `ETH_TX_CHANNELS;

  logic [N-1:0]                     desc_lo_we;
  logic [N-1:0]                     desc_hi_we;
  logic [N-1:0]                     push;
  logic [N-1:0]                     arm;
  logic [N-1:0]                     busy;
  logic [N-1:0]                     req;
  logic [N-1:0]                     grant;
  logic [N-1:0]                     chan_pop;
  logic [N-1:0][`ETH_TX_LEN_W-1:0]  len;
  eth_tx_pkg::tx_desc_t [N-1:0]     chan_desc;
  eth_tx_pkg::tx_byte_t [N-1:0]     chan_head;
  logic [31:0]                      wdata;
  eth_tx_pkg::tx_desc_t             desc;
  eth_tx_pkg::tx_byte_t             head;
  logic                             start_rdy;
  logic                             start;
  logic                             pop;

  eth_tx_regs eth_tx_regs_inst (
    .clk        (clk),        .rst        (rst),
    .wb_cyc     (wb_cyc),     .wb_stb     (wb_stb),     .wb_we    (wb_we),
    .wb_adr     (wb_adr),     .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),   .wb_ack     (wb_ack),
    .chan_busy  (busy),       .chan_len   (len),
    .desc_lo_we (desc_lo_we), .desc_hi_we (desc_hi_we),
    .push       (push),       .arm        (arm),        .wdata    (wdata)
  );

  // One transmit channel per host slot
  for (genvar i = 0; i < N; i++) begin : g_chan
    eth_tx_chan eth_tx_chan_inst (
      .clk        (clk),           .rst        (rst),
      .desc_lo_we (desc_lo_we[i]), .desc_hi_we (desc_hi_we[i]),
      .push       (push[i]),       .arm        (arm[i]),
      .grant      (grant[i]),      .pop        (chan_pop[i]),
      .wdata      (wdata),
      .req        (req[i]),        .busy       (busy[i]),     .len (len[i]),
      .desc       (chan_desc[i]),  .head       (chan_head[i])
    );
  end

  eth_tx_arb eth_tx_arb_inst (
    .clk       (clk),       .rst      (rst),
    .start_rdy (start_rdy), .pop      (pop),
    .req       (req),       .desc_in  (chan_desc), .head_in (chan_head),
    .grant     (grant),     .desc     (desc),      .head    (head),
    .start     (start),     .chan_pop (chan_pop)
  );

  eth_tx_framer eth_tx_framer_inst (
    .clk       (clk),       .rst    (rst),
    .start     (start),     .desc   (desc),   .head   (head),
    .start_rdy (start_rdy), .pop    (pop),
    .tx_val    (tx_val),    .tx_sof (tx_sof), .tx_eof (tx_eof),
    .tx_dat    (tx_dat)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -Wno-fatal --top-module eth_tx_tb -f build.f
out=$(./obj_dir/Veth_tx_tb 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS"
